// File: logic/icache_pkg.sv
/* icache shared definitions */
package icache_pkg;

    // geometry
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 256;
    localparam int BEATS_PER_LINE = 4;

    typedef logic [31:0]  addr_t;

    // address bits 31..12
    typedef logic [19:0]  tag_t;

    // address bits 11..4
    typedef logic [7:0]   index_t;

    // one bridge beat
    typedef logic [31:0]  word_t;

    // beat k sits at bits 32k+31..32k
    typedef logic [127:0] line_t;

    typedef logic [NUM_WAYS-1:0] way_vec_t;
    typedef logic [1:0]   beat_cnt_t;

    // supported cache operation codes
    typedef enum logic [1:0] {
        cacop_init  = 2'd0,
        cacop_index = 2'd1,
        cacop_hit   = 2'd2
    } cacop_code_t;

endpackage

// File: logic/icache_way_ram.sv
/* icache way storage */
`timescale 1ns/1ps

module icache_way_ram (
    input  logic                clock,
    input  logic                reset,
    input  logic                en_i,
    input  logic                we_i,
    input  icache_pkg::index_t  index_i,
    input  icache_pkg::tag_t    tag_wr_i,
    input  logic                valid_wr_i,
    input  icache_pkg::line_t   line_wr_i,
    input  logic                data_we_i,
    output icache_pkg::tag_t    tag_o,
    output logic                valid_o,
    output icache_pkg::line_t   line_o
);
    import icache_pkg::*;

    tag_t  tag_mem   [NUM_SETS];
    logic  valid_mem [NUM_SETS];
    line_t line_mem  [NUM_SETS];

    // valid bits all drop in the single reset cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_mem[s] <= 1'b0;
            end
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_o <= valid_mem[index_i];
            if (we_i) begin
                valid_mem[index_i] <= valid_wr_i;
            end
        end
    end

    // tag and line, read returns the old contents
    always_ff @(posedge clock) begin
        if (en_i) begin
            tag_o  <= tag_mem[index_i];
            line_o <= line_mem[index_i];
            if (we_i) begin
                tag_mem[index_i] <= tag_wr_i;
                // invalidates leave the line alone
                if (data_we_i) begin
                    line_mem[index_i] <= line_wr_i;
                end
            end
        end
    end

endmodule

// File: logic/icache_lookup.sv
/* icache tag compare */
`timescale 1ns/1ps

module icache_lookup (
    input  icache_pkg::tag_t      req_tag_i,
    input  icache_pkg::tag_t      way0_tag_i,
    input  icache_pkg::tag_t      way1_tag_i,
    input  icache_pkg::way_vec_t  way_valid_i,
    input  icache_pkg::line_t     way0_line_i,
    input  icache_pkg::line_t     way1_line_i,
    output icache_pkg::way_vec_t  hit_way_o,
    output icache_pkg::line_t     hit_line_o
);
    import icache_pkg::*;

    // a way hits only when its stored copy is valid
    assign hit_way_o[0] = way_valid_i[0] && (way0_tag_i == req_tag_i);
    assign hit_way_o[1] = way_valid_i[1] && (way1_tag_i == req_tag_i);

    // and-or select, zero when nothing hits
    assign hit_line_o =
        ({$bits(line_t){hit_way_o[0]}} & way0_line_i) |
        ({$bits(line_t){hit_way_o[1]}} & way1_line_i);

    // refill never installs a tag that another way already holds
    a_hit_onehot: assert final ($isunknown(hit_way_o) || $onehot0(hit_way_o));

endmodule

// File: logic/icache_refill.sv
/* icache line refill */
`timescale 1ns/1ps

module icache_refill (
    input  logic               clock,
    input  logic               reset,
    input  logic               start_i,
    input  logic               ret_valid_i,
    input  logic               ret_last_i,
    input  icache_pkg::word_t  ret_data_i,
    output logic               line_done_o,
    output icache_pkg::line_t  line_o
);
    import icache_pkg::*;

    beat_cnt_t beat_cnt;

    // first three beats of the line
    word_t     beat_buf [BEATS_PER_LINE-1];

    // last marker or the fourth counted beat closes the line
    assign line_done_o = ret_valid_i &&
        (ret_last_i || (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1)));

    always_ff @(posedge clock) begin
        if (reset || start_i) begin
            beat_cnt <= '0;
        end else if (ret_valid_i) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (ret_valid_i && !line_done_o) begin
            beat_buf[beat_cnt] <= ret_data_i;
        end
    end

    // current beat goes on top, so the line is ready in the final beat cycle
    assign line_o = {ret_data_i, beat_buf[2], beat_buf[1], beat_buf[0]};

    // the bridge always sends full lines
    a_last_on_fourth: assert property (@(posedge clock) disable iff (reset)
        ret_valid_i && ret_last_i |-> beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1));

endmodule

// File: logic/icache_lru.sv
/* icache replacement choice */
`timescale 1ns/1ps

module icache_lru (
    input  logic                  clock,
    input  logic                  reset,
    input  icache_pkg::index_t    index_i,
    input  icache_pkg::way_vec_t  way_valid_i,
    input  logic                  touch_i,
    input  icache_pkg::way_vec_t  touch_way_i,
    output icache_pkg::way_vec_t  victim_o
);
    import icache_pkg::*;

    // one bit per set, set means way 1 was used last
    logic mru_mem [NUM_SETS];
    logic mru_cur;

    assign mru_cur = mru_mem[index_i];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                mru_mem[s] <= 1'b0;
            end
        end else if (touch_i) begin
            mru_mem[index_i] <= touch_way_i[1];
        end
    end

    // empty ways first, lowest number wins
    always_comb begin
        if (!way_valid_i[0]) begin
            victim_o = 2'b01;
        end else if (!way_valid_i[1]) begin
            victim_o = 2'b10;
        end else if (mru_cur) begin
            victim_o = 2'b01;
        end else begin
            victim_o = 2'b10;
        end
    end

endmodule

// File: logic/icache_ctrl.sv
/* icache controller */
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                     clock,
    input  logic                     reset,
    // cpu side
    input  logic                     valid_i,
    input  icache_pkg::addr_t        araddr_i,
    input  logic                     uncached_i,
    input  logic                     cacop_en_i,
    input  icache_pkg::cacop_code_t  cacop_code_i,
    input  icache_pkg::addr_t        cacop_addr_i,
    output logic                     ready_o,
    output logic                     rvalid_o,
    output logic                     rhit_o,
    output icache_pkg::line_t        rdata_o,
    // bridge side
    output logic                     rd_req_o,
    output icache_pkg::addr_t        rd_addr_o,
    input  logic                     rd_rdy_i,
    // way rams
    output logic                     ram_en_o,
    output icache_pkg::index_t       ram_index_o,
    output icache_pkg::way_vec_t     tag_we_o,
    output logic                     data_we_o,
    output icache_pkg::tag_t         tag_wr_o,
    output logic                     valid_wr_o,
    input  icache_pkg::way_vec_t     way_valid_i,
    // lookup, refill and lru
    output icache_pkg::tag_t         req_tag_o,
    input  icache_pkg::way_vec_t     hit_way_i,
    input  icache_pkg::line_t        hit_line_i,
    output logic                     refill_start_o,
    input  logic                     line_done_i,
    input  icache_pkg::line_t        refill_line_i,
    output logic                     lru_touch_o,
    output icache_pkg::way_vec_t     lru_way_o,
    output icache_pkg::way_vec_t     lru_valid_o,
    input  icache_pkg::way_vec_t     victim_i
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_request,
        st_receive,
        st_cacop
    } ctrl_state_t;

    ctrl_state_t state;

    // request buffer
    tag_t     req_tag;
    index_t   req_index;
    logic     req_uncached;

    // way valid bits as seen at lookup
    way_vec_t valid_seen;

    logic     accept;
    logic     lookup_hit;
    logic     lookup_miss;
    logic     receive_ret;
    logic     fill;
    logic     idle_inval;
    way_vec_t inval_way;

    assign accept      = valid_i && ready_o;
    assign lookup_hit  = (state == st_lookup) && (|hit_way_i);
    assign lookup_miss = (state == st_lookup) && !(|hit_way_i);
    assign receive_ret = (state == st_receive) && line_done_i;
    assign fill        = receive_ret && !req_uncached;

    // index-type cacops write straight from idle
    assign idle_inval = accept && cacop_en_i &&
        (cacop_code_i == cacop_init || cacop_code_i == cacop_index);
    assign inval_way  = cacop_addr_i[0] ? 2'b10 : 2'b01;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (cacop_en_i) begin
                            if (cacop_code_i == cacop_hit) begin
                                state <= st_cacop;
                            end
                        end else if (uncached_i) begin
                            state <= st_request;
                        end else begin
                            state <= st_lookup;
                        end
                    end
                end
                st_lookup: begin
                    if (lookup_hit) begin
                        state <= st_idle;
                    end else if (rd_rdy_i) begin
                        state <= st_receive;
                    end else begin
                        state <= st_request;
                    end
                end
                st_request: begin
                    if (rd_rdy_i) begin
                        state <= st_receive;
                    end
                end
                st_receive: begin
                    if (line_done_i) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            if (cacop_en_i) begin
                req_tag   <= cacop_addr_i[31:12];
                req_index <= cacop_addr_i[11:4];
            end else begin
                req_tag   <= araddr_i[31:12];
                req_index <= araddr_i[11:4];
            end
            req_uncached <= uncached_i && !cacop_en_i;
        end
        if (state == st_lookup) begin
            valid_seen <= way_valid_i;
        end
    end

    // cpu return
    assign ready_o  = (state == st_idle);
    assign rvalid_o = lookup_hit || receive_ret;
    assign rhit_o   = lookup_hit;
    assign rdata_o  =
        ({$bits(line_t){lookup_hit}}  & hit_line_i) |
        ({$bits(line_t){receive_ret}} & refill_line_i);

    // bridge read request already rises in the missing lookup cycle
    assign rd_req_o       = lookup_miss || (state == st_request);
    assign rd_addr_o      = {req_tag, req_index, 4'b0000};
    assign refill_start_o = rd_req_o && rd_rdy_i;

    // idle reads straight from the incoming address
    assign ram_index_o = (state != st_idle) ? req_index :
                         cacop_en_i         ? cacop_addr_i[11:4] : araddr_i[11:4];
    assign ram_en_o    = accept || fill || (state == st_cacop);
    assign data_we_o   = fill;
    assign tag_wr_o    = req_tag;
    assign valid_wr_o  = fill;

    always_comb begin
        tag_we_o = '0;
        if (idle_inval) begin
            tag_we_o = inval_way;
        end else if (fill) begin
            tag_we_o = victim_i;
        end else if (state == st_cacop) begin
            tag_we_o = hit_way_i;
        end
    end

    assign req_tag_o   = req_tag;
    assign lru_touch_o = lookup_hit || fill;
    assign lru_way_o   = lookup_hit ? hit_way_i : victim_i;
    assign lru_valid_o = valid_seen;

    // the bridge read holds its address until the bridge takes it
    a_req_held: assert property (@(posedge clock) disable iff (reset)
        rd_req_o && !rd_rdy_i |=> rd_req_o && $stable(rd_addr_o));

endmodule

// File: logic/icache_top.sv
/* two-way instruction cache */
`timescale 1ns/1ps

module icache_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     valid_i,
    output logic                     ready_o,
    input  icache_pkg::addr_t        araddr_i,
    input  logic                     uncached_i,
    output logic                     rvalid_o,
    output icache_pkg::line_t        rdata_o,
    output logic                     rhit_o,
    input  logic                     cacop_en_i,
    input  icache_pkg::cacop_code_t  cacop_code_i,
    input  icache_pkg::addr_t        cacop_addr_i,
    output logic                     rd_req_o,
    output icache_pkg::addr_t        rd_addr_o,
    input  logic                     rd_rdy_i,
    input  logic                     ret_valid_i,
    input  logic                     ret_last_i,
    input  icache_pkg::word_t        ret_data_i
);
    import icache_pkg::*;

    logic     ram_en;
    index_t   ram_index;
    way_vec_t tag_we;
    logic     data_we;
    tag_t     tag_wr;
    logic     valid_wr;
    tag_t     req_tag;
    logic     refill_start;
    logic     line_done;
    line_t    refill_line;
    logic     lru_touch;
    way_vec_t lru_way;
    way_vec_t lru_valid;
    way_vec_t victim;
    way_vec_t hit_way;
    line_t    hit_line;

    // way ram outputs
    tag_t     way0_tag;
    tag_t     way1_tag;
    logic     way0_valid;
    logic     way1_valid;
    line_t    way0_line;
    line_t    way1_line;
    way_vec_t way_valid;

    assign way_valid = {way1_valid, way0_valid};

    icache_ctrl i_ctrl (
        .clock          (clock),
        .reset          (reset),
        .valid_i        (valid_i),
        .araddr_i       (araddr_i),
        .uncached_i     (uncached_i),
        .cacop_en_i     (cacop_en_i),
        .cacop_code_i   (cacop_code_i),
        .cacop_addr_i   (cacop_addr_i),
        .ready_o        (ready_o),
        .rvalid_o       (rvalid_o),
        .rhit_o         (rhit_o),
        .rdata_o        (rdata_o),
        .rd_req_o       (rd_req_o),
        .rd_addr_o      (rd_addr_o),
        .rd_rdy_i       (rd_rdy_i),
        .ram_en_o       (ram_en),
        .ram_index_o    (ram_index),
        .tag_we_o       (tag_we),
        .data_we_o      (data_we),
        .tag_wr_o       (tag_wr),
        .valid_wr_o     (valid_wr),
        .way_valid_i    (way_valid),
        .req_tag_o      (req_tag),
        .hit_way_i      (hit_way),
        .hit_line_i     (hit_line),
        .refill_start_o (refill_start),
        .line_done_i    (line_done),
        .refill_line_i  (refill_line),
        .lru_touch_o    (lru_touch),
        .lru_way_o      (lru_way),
        .lru_valid_o    (lru_valid),
        .victim_i       (victim)
    );

    icache_way_ram i_way0 (
        .clock      (clock),
        .reset      (reset),
        .en_i       (ram_en),
        .we_i       (tag_we[0]),
        .index_i    (ram_index),
        .tag_wr_i   (tag_wr),
        .valid_wr_i (valid_wr),
        .line_wr_i  (refill_line),
        .data_we_i  (data_we),
        .tag_o      (way0_tag),
        .valid_o    (way0_valid),
        .line_o     (way0_line)
    );

    icache_way_ram i_way1 (
        .clock      (clock),
        .reset      (reset),
        .en_i       (ram_en),
        .we_i       (tag_we[1]),
        .index_i    (ram_index),
        .tag_wr_i   (tag_wr),
        .valid_wr_i (valid_wr),
        .line_wr_i  (refill_line),
        .data_we_i  (data_we),
        .tag_o      (way1_tag),
        .valid_o    (way1_valid),
        .line_o     (way1_line)
    );

    icache_lookup i_lookup (
        .req_tag_i   (req_tag),
        .way0_tag_i  (way0_tag),
        .way1_tag_i  (way1_tag),
        .way_valid_i (way_valid),
        .way0_line_i (way0_line),
        .way1_line_i (way1_line),
        .hit_way_o   (hit_way),
        .hit_line_o  (hit_line)
    );

    icache_refill i_refill (
        .clock       (clock),
        .reset       (reset),
        .start_i     (refill_start),
        .ret_valid_i (ret_valid_i),
        .ret_last_i  (ret_last_i),
        .ret_data_i  (ret_data_i),
        .line_done_o (line_done),
        .line_o      (refill_line)
    );

    icache_lru i_lru (
        .clock       (clock),
        .reset       (reset),
        .index_i     (ram_index),
        .way_valid_i (lru_valid),
        .touch_i     (lru_touch),
        .touch_way_i (lru_way),
        .victim_o    (victim)
    );

endmodule

// File: tb/icache_bridge_model.sv
/* bridge read model */
`timescale 1ns/1ps

module icache_bridge_model (
    input  logic               clock,
    input  logic               reset,
    input  logic               rd_req_i,
    input  icache_pkg::addr_t  rd_addr_i,
    output logic               rd_rdy_o,
    output logic               ret_valid_o,
    output logic               ret_last_o,
    output icache_pkg::word_t  ret_data_o
);
    import icache_pkg::*;

    integer seed;
    integer gap;
    integer k;
    addr_t  line_addr;

    // everything moves on the falling edge
    initial begin
        seed        = 68;
        rd_rdy_o    = 1'b0;
        ret_valid_o = 1'b0;
        ret_last_o  = 1'b0;
        ret_data_o  = '0;
        forever begin
            @(negedge clock);
            if (!reset && rd_req_i) begin
                line_addr = rd_addr_i;
                // hold off the request for a while
                gap = $random(seed) & 3;
                repeat (gap) @(negedge clock);
                rd_rdy_o = 1'b1;
                @(negedge clock);
                rd_rdy_o = 1'b0;
                for (k = 0; k < BEATS_PER_LINE; k = k + 1) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge clock);
                    ret_valid_o = 1'b1;
                    ret_last_o  = (k == BEATS_PER_LINE - 1);
                    // beat k is the line address plus k, scrambled
                    ret_data_o  = (line_addr + k) ^ 32'hA5A5_0000;
                    @(negedge clock);
                    ret_valid_o = 1'b0;
                    ret_last_o  = 1'b0;
                    ret_data_o  = '0;
                end
            end
        end
    end

endmodule

// File: tb/icache_tb.sv
/* icache testbench */
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int MAX_ROWS = 32;
    localparam int TIMEOUT  = 200;

    // A, C and D share index 0x23, B sits at index 0x67
    localparam addr_t ADDR_A = 32'h0000_1230;
    localparam addr_t ADDR_B = 32'h0000_5670;
    localparam addr_t ADDR_C = 32'h0000_2230;
    localparam addr_t ADDR_D = 32'h0000_3230;

    logic        clock;
    logic        reset;
    logic        valid_i;
    logic        ready_o;
    addr_t       araddr_i;
    logic        uncached_i;
    logic        rvalid_o;
    line_t       rdata_o;
    logic        rhit_o;
    logic        cacop_en_i;
    cacop_code_t cacop_code_i;
    addr_t       cacop_addr_i;
    logic        rd_req_o;
    addr_t       rd_addr_o;
    logic        rd_rdy_i;
    logic        ret_valid_i;
    logic        ret_last_i;
    word_t       ret_data_i;

    // stimulus and expected values
    logic        row_cacop    [MAX_ROWS];
    cacop_code_t row_code     [MAX_ROWS];
    addr_t       row_addr     [MAX_ROWS];
    logic        row_uncached [MAX_ROWS];
    logic        row_hit      [MAX_ROWS];
    line_t       row_line     [MAX_ROWS];
    int          num_rows;
    int          error_count;

    initial clock = 1'b0;
    always #5 clock = ~clock;

    icache_top i_icache_top (
        .clock        (clock),
        .reset        (reset),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .araddr_i     (araddr_i),
        .uncached_i   (uncached_i),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .rhit_o       (rhit_o),
        .cacop_en_i   (cacop_en_i),
        .cacop_code_i (cacop_code_i),
        .cacop_addr_i (cacop_addr_i),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .rd_rdy_i     (rd_rdy_i),
        .ret_valid_i  (ret_valid_i),
        .ret_last_i   (ret_last_i),
        .ret_data_i   (ret_data_i)
    );

    icache_bridge_model i_bridge (
        .clock       (clock),
        .reset       (reset),
        .rd_req_i    (rd_req_o),
        .rd_addr_i   (rd_addr_o),
        .rd_rdy_o    (rd_rdy_i),
        .ret_valid_o (ret_valid_i),
        .ret_last_o  (ret_last_i),
        .ret_data_o  (ret_data_i)
    );

    // beat k of a line is its address plus k, scrambled
    function automatic line_t expected_line(input addr_t addr);
        addr_t base;
        line_t line;
        int    k;
        base = {addr[31:4], 4'b0000};
        for (k = 0; k < BEATS_PER_LINE; k++) begin
            line[32*k +: 32] = (base + k) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    task automatic add_fetch(input addr_t addr, input logic uncached, input logic hit);
        row_cacop[num_rows]    = 1'b0;
        row_code[num_rows]     = cacop_init;
        row_addr[num_rows]     = addr;
        row_uncached[num_rows] = uncached;
        row_hit[num_rows]      = hit;
        row_line[num_rows]     = expected_line(addr);
        num_rows++;
    endtask

    task automatic add_cacop(input cacop_code_t code, input addr_t addr);
        row_cacop[num_rows]    = 1'b1;
        row_code[num_rows]     = code;
        row_addr[num_rows]     = addr;
        row_uncached[num_rows] = 1'b0;
        row_hit[num_rows]      = 1'b0;
        row_line[num_rows]     = '0;
        num_rows++;
    endtask

    task automatic build_table();
        add_fetch(ADDR_A, 1'b0, 1'b0);
        add_fetch(ADDR_A, 1'b0, 1'b1);
        add_fetch(ADDR_B, 1'b1, 1'b0);
        add_fetch(ADDR_B, 1'b0, 1'b0);
        // C fills way 1, A becomes most recent, D then evicts C
        add_fetch(ADDR_C, 1'b0, 1'b0);
        add_fetch(ADDR_A, 1'b0, 1'b1);
        add_fetch(ADDR_D, 1'b0, 1'b0);
        add_fetch(ADDR_A, 1'b0, 1'b1);
        add_fetch(ADDR_C, 1'b0, 1'b0);
        // way select comes from address bit 0
        add_cacop(cacop_index, 32'h0000_0230);
        add_fetch(ADDR_A, 1'b0, 1'b0);
        add_cacop(cacop_init, 32'h0000_0231);
        add_fetch(ADDR_C, 1'b0, 1'b0);
        add_fetch(ADDR_A, 1'b0, 1'b1);
        add_cacop(cacop_hit, ADDR_A);
        add_fetch(ADDR_A, 1'b0, 1'b0);
        add_fetch(ADDR_A, 1'b0, 1'b1);
        // D is not cached so nothing changes
        add_cacop(cacop_hit, ADDR_D);
        add_fetch(ADDR_C, 1'b0, 1'b1);
        add_fetch(ADDR_A, 1'b0, 1'b1);
        add_fetch(ADDR_B, 1'b1, 1'b0);
        add_fetch(ADDR_B, 1'b0, 1'b1);
        // C sits in way 1
        add_cacop(cacop_hit, ADDR_C);
        add_fetch(ADDR_C, 1'b0, 1'b0);
    endtask

    task automatic check_line(input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("Error: %0d ns: line %h, expected %h", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic check_hit(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %0d ns: rhit %b, expected %b", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic check_request(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %0d ns: bridge request %b, expected %b", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Error: %0d ns: bridge address %h, expected %h", $time, got, exp);
            error_count++;
        end
    endtask

    // outputs are sampled at the rising edge before any register updates
    task automatic wait_return(input int r, output bit ok);
        int   waited;
        logic req_seen;
        waited   = 0;
        req_seen = 1'b0;
        do begin
            @(posedge clock);
            waited++;
            if (rd_req_o) begin
                req_seen = 1'b1;
                check_addr(rd_addr_o, {row_addr[r][31:4], 4'b0000});
            end
        end while (!rvalid_o && waited < TIMEOUT);
        ok = rvalid_o;
        if (!rvalid_o) begin
            $display("timeout: no line came back for row %0d", r);
        end else begin
            check_line(rdata_o, row_line[r]);
            check_hit(rhit_o, row_hit[r]);
            // only a hit is served without a bridge read
            check_request(req_seen, !row_hit[r]);
        end
    endtask

    task automatic wait_idle(input int r, output bit ok);
        int waited;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (rvalid_o) begin
                $display("Error: %0d ns: cache operation of row %0d returned a line",
                         $time, r);
                error_count++;
            end
        end while (!ready_o && waited < TIMEOUT);
        ok = ready_o;
        if (!ready_o) begin
            $display("timeout: cache stayed busy after row %0d", r);
        end
    endtask

    task automatic run_row(input int r, output bit ok);
        int waited;
        @(negedge clock);
        valid_i      = 1'b1;
        cacop_en_i   = row_cacop[r];
        cacop_code_i = row_code[r];
        cacop_addr_i = row_addr[r];
        araddr_i     = row_addr[r];
        uncached_i   = row_uncached[r];
        waited = 0;
        @(posedge clock);
        while (!ready_o && waited < TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (!ready_o) begin
            $display("timeout: request of row %0d was never accepted", r);
            ok = 1'b0;
        end else begin
            @(negedge clock);
            valid_i    = 1'b0;
            cacop_en_i = 1'b0;
            if (row_cacop[r]) begin
                wait_idle(r, ok);
            end else begin
                wait_return(r, ok);
            end
        end
    endtask

    initial begin
        int    r;
        int    errors_before;
        int    rows_passed;
        bit    ok;
        bit    timed_out;
        string kind;
        reset        = 1'b1;
        valid_i      = 1'b0;
        araddr_i     = '0;
        uncached_i   = 1'b0;
        cacop_en_i   = 1'b0;
        cacop_code_i = cacop_init;
        cacop_addr_i = '0;
        num_rows     = 0;
        error_count  = 0;
        rows_passed  = 0;
        timed_out    = 1'b0;
        build_table();
        repeat (5) @(negedge clock);
        reset = 1'b0;
        r = 0;
        while (r < num_rows && !timed_out) begin
            errors_before = error_count;
            run_row(r, ok);
            timed_out = !ok;
            if (row_cacop[r]) begin
                kind = $sformatf("cacop %0d", row_code[r]);
            end else begin
                kind = row_uncached[r] ? "uncached fetch" : "fetch";
            end
            if (ok && error_count == errors_before) begin
                rows_passed++;
                $display("row %0d %s %h: ok", r, kind, row_addr[r]);
            end else begin
                $display("row %0d %s %h: failed", r, kind, row_addr[r]);
            end
            r++;
        end
        $display("%0d of %0d rows passed, %0d errors", rows_passed, num_rows, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/icache_pkg.sv
logic/icache_way_ram.sv
logic/icache_lookup.sv
logic/icache_refill.sv
logic/icache_lru.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tb/icache_bridge_model.sv
tb/icache_tb.sv
